/* mem_types_pkg.sv */
/* data word and address types of the burst memory subsystem
   widths are fixed here and shared by every block and the testbench */
`default_nettype none

package mem_types_pkg;

  localparam int ADDR_W = 8;   // 256 words
  localparam int DATA_W = 64;

  // one memory data word
  typedef logic [DATA_W-1:0] word_t;

  // word address, not a byte address
  typedef logic [ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

/* mem_ctrl_pkg.sv */
/* command encoding of the burst RAM and the state encodings of
   the RAM model and the line controller FSMs */
`default_nettype none

package mem_ctrl_pkg;

  typedef logic cmd_t;

  localparam cmd_t CMD_READ  = 1'b0;
  localparam cmd_t CMD_WRITE = 1'b1;

  typedef enum logic [2:0] {
    ram_calibrate,    // counting out the power-up delay
    ram_idle,
    ram_read_delay,   // waiting out the read latency
    ram_read_burst,
    ram_write_burst
  } ram_state_e;

  typedef enum logic [1:0] {
    ctrl_wait_cal,
    ctrl_idle,
    ctrl_issue,       // cmd_en cycle
    ctrl_wait_done
  } ctrl_state_e;

endpackage

`default_nettype wire

/* burst_ram.sv */
/* mock external burst memory core for simulation
   calibrates after reset, then accepts one burst command at a time on cmd_en
   reads stream BURST_LEN words after READ_LAT cycles, writes take one word per cycle */
`timescale 1ns/1ps
`default_nettype none

module burst_ram #(
  parameter int BURST_LEN   = 4,
  parameter int INIT_CYCLES = 10,
  parameter int READ_LAT    = 6
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire mem_ctrl_pkg::cmd_t   cmd,
  input  wire                       cmd_en,
  input  wire mem_types_pkg::addr_t addr,
  input  wire mem_types_pkg::word_t wr_data,
  output mem_types_pkg::word_t      rd_data,
  output logic                      rd_data_valid,
  output logic                      init_calib,
  output logic                      busy
);

  localparam int DEPTH  = 2 ** mem_types_pkg::ADDR_W;
  localparam int BEAT_W = $clog2(BURST_LEN);
  localparam int MAX_DLY = (INIT_CYCLES > READ_LAT) ? INIT_CYCLES : READ_LAT;
  localparam int CNT_W  = $clog2(MAX_DLY + 1);
  localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(BURST_LEN - 1);

  mem_types_pkg::word_t     mem [DEPTH];
  mem_ctrl_pkg::ram_state_e state;
  logic [CNT_W-1:0]         delay_cnt;   // shared by calibration and read latency
  logic [BEAT_W-1:0]        beat_cnt;
  mem_types_pkg::addr_t     addr_cnt;
  logic                     mem_we;
  mem_types_pkg::addr_t     mem_waddr;
  logic                     rd_load;
  logic                     cal_done;
  logic                     lat_done;

  assign cal_done = (delay_cnt == CNT_W'(INIT_CYCLES));
  assign lat_done = (delay_cnt == CNT_W'(READ_LAT - 1));   // valid lands one cycle later

  // storage strobes, decoded from the FSM state
  always_comb begin
    mem_we    = 1'b0;
    mem_waddr = addr_cnt;
    rd_load   = 1'b0;
    case (state)
      mem_ctrl_pkg::ram_idle: begin
        // first write word goes in with the command itself
        mem_we    = cmd_en && (cmd == mem_ctrl_pkg::CMD_WRITE);
        mem_waddr = addr;
      end
      mem_ctrl_pkg::ram_read_delay:  rd_load = lat_done;
      mem_ctrl_pkg::ram_read_burst:  rd_load = (beat_cnt != LAST_BEAT);
      mem_ctrl_pkg::ram_write_burst: mem_we = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_waddr] <= wr_data;
    end
    if (rd_load) begin
      rd_data <= mem[addr_cnt];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= mem_ctrl_pkg::ram_calibrate;
      busy          <= 1'b1;
      init_calib    <= 1'b0;
      rd_data_valid <= 1'b0;
      delay_cnt     <= '0;
      beat_cnt      <= '0;
      addr_cnt      <= '0;
    end else begin
      case (state)
        mem_ctrl_pkg::ram_calibrate: begin
          delay_cnt <= delay_cnt + 1'b1;
          if (cal_done) begin
            init_calib <= 1'b1;
            busy       <= 1'b0;
            state      <= mem_ctrl_pkg::ram_idle;
          end
        end

        mem_ctrl_pkg::ram_idle: begin
          if (cmd_en) begin
            busy      <= 1'b1;
            delay_cnt <= '0;
            if (cmd == mem_ctrl_pkg::CMD_WRITE) begin
              addr_cnt <= addr + 1'b1;       // word 0 already stored
              beat_cnt <= BEAT_W'(1);
              state    <= mem_ctrl_pkg::ram_write_burst;
            end else begin
              addr_cnt <= addr;
              state    <= mem_ctrl_pkg::ram_read_delay;
            end
          end
        end

        mem_ctrl_pkg::ram_read_delay: begin
          delay_cnt <= delay_cnt + 1'b1;
          if (lat_done) begin
            rd_data_valid <= 1'b1;
            addr_cnt      <= addr_cnt + 1'b1;
            beat_cnt      <= '0;
            state         <= mem_ctrl_pkg::ram_read_burst;
          end
        end

        mem_ctrl_pkg::ram_read_burst: begin
          if (beat_cnt == LAST_BEAT) begin
            rd_data_valid <= 1'b0;
            busy          <= 1'b0;
            state         <= mem_ctrl_pkg::ram_idle;
          end else begin
            beat_cnt <= beat_cnt + 1'b1;
            addr_cnt <= addr_cnt + 1'b1;
          end
        end

        mem_ctrl_pkg::ram_write_burst: begin
          if (beat_cnt == LAST_BEAT) begin
            busy  <= 1'b0;                   // last word stored this cycle
            state <= mem_ctrl_pkg::ram_idle;
          end else begin
            beat_cnt <= beat_cnt + 1'b1;
            addr_cnt <= addr_cnt + 1'b1;
          end
        end

        default: state <= mem_ctrl_pkg::ram_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* line_ctrl.sv */
/* line controller between the client and the burst RAM
   waits for calibration, turns a req pulse into one burst command,
   sequences write beats and pulses done once the RAM goes idle */
`timescale 1ns/1ps
`default_nettype none

module line_ctrl #(
  parameter int BURST_LEN = 4
) (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         req,
  input  wire                         req_write,
  input  wire mem_types_pkg::addr_t   req_addr,
  input  wire                         init_calib,
  input  wire                         busy,
  output mem_ctrl_pkg::cmd_t          cmd,
  output logic                        cmd_en,
  output mem_types_pkg::addr_t        addr,
  output logic [$clog2(BURST_LEN)-1:0] wr_beat,
  output logic                        rd_start,
  output logic                        wr_clear,
  output logic                        ready,
  output logic                        done
);

  localparam int BEAT_W = $clog2(BURST_LEN);
  localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(BURST_LEN - 1);

  mem_ctrl_pkg::ctrl_state_e state;
  logic                      op_write;   // latched req_write

  assign ready    = (state == mem_ctrl_pkg::ctrl_idle);
  assign cmd_en   = (state == mem_ctrl_pkg::ctrl_issue);
  assign rd_start = cmd_en && !op_write;
  assign cmd      = op_write ? mem_ctrl_pkg::CMD_WRITE : mem_ctrl_pkg::CMD_READ;

  // address only matters while a command is out
  always_ff @(posedge clk) begin
    if (ready && req) begin
      addr <= req_addr;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= mem_ctrl_pkg::ctrl_wait_cal;
      op_write <= 1'b0;
      wr_beat  <= '0;
      done     <= 1'b0;
      wr_clear <= 1'b0;
    end else begin
      done     <= 1'b0;
      wr_clear <= 1'b0;

      // beat k lines up with the k-th cycle after cmd_en
      if (state == mem_ctrl_pkg::ctrl_idle) begin
        wr_beat <= '0;
      end else if (op_write && wr_beat != LAST_BEAT &&
                   (state == mem_ctrl_pkg::ctrl_issue ||
                    state == mem_ctrl_pkg::ctrl_wait_done)) begin
        wr_beat <= wr_beat + 1'b1;
      end

      case (state)
        mem_ctrl_pkg::ctrl_wait_cal: begin
          if (init_calib) begin
            state <= mem_ctrl_pkg::ctrl_idle;
          end
        end

        mem_ctrl_pkg::ctrl_idle: begin
          if (req) begin
            op_write <= req_write;
            state    <= mem_ctrl_pkg::ctrl_issue;
          end
        end

        mem_ctrl_pkg::ctrl_issue: state <= mem_ctrl_pkg::ctrl_wait_done;

        mem_ctrl_pkg::ctrl_wait_done: begin
          if (done) begin
            state <= mem_ctrl_pkg::ctrl_idle;   // ready one cycle after done
          end else if (!busy) begin
            done     <= 1'b1;
            wr_clear <= op_write;
          end
        end

        default: state <= mem_ctrl_pkg::ctrl_wait_cal;
      endcase
    end
  end

endmodule

`default_nettype wire

/* wr_line_buf.sv */
/* write line buffer
   collects up to BURST_LEN client words, then feeds one per beat to the RAM
   the fill count is cleared by the controller when a write burst finishes */
`timescale 1ns/1ps
`default_nettype none

module wr_line_buf #(
  parameter int BURST_LEN = 4
) (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           wr_push,
  input  wire mem_types_pkg::word_t     wr_word,
  input  wire                           wr_clear,
  input  wire [$clog2(BURST_LEN)-1:0]   wr_beat,
  output mem_types_pkg::word_t          wr_data,
  output logic                          line_full
);

  localparam int BEAT_W = $clog2(BURST_LEN);
  localparam int FILL_W = $clog2(BURST_LEN + 1);

  mem_types_pkg::word_t slots [BURST_LEN];
  logic [FILL_W-1:0]    fill;
  logic                 push_ok;

  assign line_full = (fill == FILL_W'(BURST_LEN));
  assign push_ok   = wr_push && !line_full && !wr_clear;   // extra pushes are lost
  assign wr_data   = slots[wr_beat];

  always_ff @(posedge clk) begin
    if (push_ok) begin
      slots[fill[BEAT_W-1:0]] <= wr_word;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill <= '0;
    end else if (wr_clear) begin
      fill <= '0;       // old words stay in the slots
    end else if (push_ok) begin
      fill <= fill + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rd_line_buf.sv */
/* read line buffer
   captures the beats of a read burst in arrival order
   and returns the word picked by rd_sel */
`timescale 1ns/1ps
`default_nettype none

module rd_line_buf #(
  parameter int BURST_LEN = 4
) (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         rd_start,
  input  wire                         rd_data_valid,
  input  wire mem_types_pkg::word_t   rd_data,
  input  wire [$clog2(BURST_LEN)-1:0] rd_sel,
  output mem_types_pkg::word_t        rd_word
);

  localparam int BEAT_W = $clog2(BURST_LEN);

  mem_types_pkg::word_t slots [BURST_LEN];
  logic [BEAT_W-1:0]    cap_idx;    // next slot to fill

  assign rd_word = slots[rd_sel];

  always_ff @(posedge clk) begin
    if (rd_data_valid) begin
      slots[cap_idx] <= rd_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap_idx <= '0;
    end else if (rd_start) begin
      cap_idx <= '0;
    end else if (rd_data_valid) begin
      cap_idx <= cap_idx + 1'b1;   // wraps after the last beat
    end
  end

endmodule

`default_nettype wire

/* burst_mem_top.sv */
/* top of the burst memory subsystem
   ties the line controller, the two line buffers and the mock RAM together
   burst length and RAM delays are set here and passed down */
`timescale 1ns/1ps
`default_nettype none

module burst_mem_top #(
  parameter int BURST_LEN   = 4,
  parameter int INIT_CYCLES = 10,
  parameter int READ_LAT    = 6
) (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         wr_push,
  input  wire mem_types_pkg::word_t   wr_word,
  input  wire                         req,
  input  wire                         req_write,
  input  wire mem_types_pkg::addr_t   req_addr,
  input  wire [$clog2(BURST_LEN)-1:0] rd_sel,
  output mem_types_pkg::word_t        rd_word,
  output logic                        line_full,
  output logic                        ready,
  output logic                        done
);

  localparam int BEAT_W = $clog2(BURST_LEN);

  mem_ctrl_pkg::cmd_t   cmd;
  logic                 cmd_en;
  mem_types_pkg::addr_t addr;
  logic [BEAT_W-1:0]    wr_beat;
  logic                 rd_start;
  logic                 wr_clear;
  logic                 busy;
  logic                 init_calib;
  mem_types_pkg::word_t wr_data;
  mem_types_pkg::word_t rd_data;
  logic                 rd_data_valid;

  line_ctrl #(
    .BURST_LEN (BURST_LEN)
  ) u_line_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .req_write  (req_write),
    .req_addr   (req_addr),
    .init_calib (init_calib),
    .busy       (busy),
    .cmd        (cmd),
    .cmd_en     (cmd_en),
    .addr       (addr),
    .wr_beat    (wr_beat),
    .rd_start   (rd_start),
    .wr_clear   (wr_clear),
    .ready      (ready),
    .done       (done)
  );

  wr_line_buf #(
    .BURST_LEN (BURST_LEN)
  ) u_wr_line_buf (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_push   (wr_push),
    .wr_word   (wr_word),
    .wr_clear  (wr_clear),
    .wr_beat   (wr_beat),
    .wr_data   (wr_data),
    .line_full (line_full)
  );

  rd_line_buf #(
    .BURST_LEN (BURST_LEN)
  ) u_rd_line_buf (
    .clk           (clk),
    .rst_n         (rst_n),
    .rd_start      (rd_start),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data),
    .rd_sel        (rd_sel),
    .rd_word       (rd_word)
  );

  burst_ram #(
    .BURST_LEN   (BURST_LEN),
    .INIT_CYCLES (INIT_CYCLES),
    .READ_LAT    (READ_LAT)
  ) u_burst_ram (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd           (cmd),
    .cmd_en        (cmd_en),
    .addr          (addr),
    .wr_data       (wr_data),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid),
    .init_calib    (init_calib),
    .busy          (busy)
  );

endmodule

`default_nettype wire

/* tb_burst_mem.sv */
/* self-checking testbench for the burst memory subsystem
   replays the operations of burst_stim.txt against burst_mem_top and checks
   read-back words, line_full, ready and done against the line rules */
`timescale 1ns/1ps
`default_nettype none

module tb_burst_mem;

  localparam int BURST_LEN = 4;
  localparam int SEL_W     = $clog2(BURST_LEN);
  localparam int TIMEOUT   = 200;   // cycles allowed per wait

  logic                 clk;
  logic                 rst_n;
  logic                 wr_push;
  mem_types_pkg::word_t wr_word;
  logic                 req;
  logic                 req_write;
  mem_types_pkg::addr_t req_addr;
  logic [SEL_W-1:0]     rd_sel;
  mem_types_pkg::word_t rd_word;
  logic                 line_full;
  logic                 ready;
  logic                 done;

  int value_errs;
  int other_errs;
  int done_seen;
  int done_exp;
  int fill_model;      // expected write buffer fill
  bit pending;         // a transaction is in flight
  bit pending_write;

  burst_mem_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_push   (wr_push),
    .wr_word   (wr_word),
    .req       (req),
    .req_write (req_write),
    .req_addr  (req_addr),
    .rd_sel    (rd_sel),
    .rd_word   (rd_word),
    .line_full (line_full),
    .ready     (ready),
    .done      (done)
  );

  always #10 clk = ~clk;

  // every done pulse, wanted or not
  always @(negedge clk) begin
    if (rst_n && done) begin
      done_seen++;
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic wait_ready(input string what);
    int n;
    n = 0;
    while (!ready && n < TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (!ready) begin
      $display("timeout while waiting for ready before %s", what);
      other_errs++;
    end
  endtask

  task automatic finish_pending();
    int n;
    if (pending) begin
      n = 0;
      while (!done && n < TIMEOUT) begin
        next_cycle();
        n++;
      end
      if (!done) begin
        $display("timeout while waiting for done of a transaction");
        other_errs++;
      end else begin
        if (pending_write) begin
          fill_model = 0;   // finished write empties the line
        end
        next_cycle();
        if (line_full !== (fill_model == BURST_LEN)) begin
          $display("[FAIL] line_full got 0x%h expected 0x%h", line_full,
                   (fill_model == BURST_LEN));
          value_errs++;
        end
      end
      pending = 1'b0;
    end
  endtask

  task automatic push_word(input mem_types_pkg::word_t w);
    wr_push = 1'b1;
    wr_word = w;
    next_cycle();
    wr_push = 1'b0;
    if (fill_model < BURST_LEN) begin
      fill_model++;
    end
    if (line_full !== (fill_model == BURST_LEN)) begin
      $display("[FAIL] line_full got 0x%h expected 0x%h", line_full,
               (fill_model == BURST_LEN));
      value_errs++;
    end
  endtask

  task automatic issue_req(input bit write, input mem_types_pkg::addr_t a);
    wait_ready(write ? "a write request" : "a read request");
    req       = 1'b1;
    req_write = write;
    req_addr  = a;
    next_cycle();
    req           = 1'b0;
    pending       = 1'b1;
    pending_write = write;
    done_exp++;
  endtask

  // request while a transaction runs, must be ignored
  task automatic stray_req(input mem_types_pkg::addr_t a);
    if (ready) begin
      $display("ready was high when the stray request was made");
      other_errs++;
    end
    req       = 1'b1;
    req_write = 1'b1;
    req_addr  = a;
    next_cycle();
    req = 1'b0;
  endtask

  task automatic check_word(input logic [SEL_W-1:0] idx, input mem_types_pkg::word_t exp);
    rd_sel = idx;
    next_cycle();   // rd_word follows rd_sel combinationally
    if (rd_word !== exp) begin
      $display("[FAIL] rd_word[%0d] got 0x%h expected 0x%h", idx, rd_word, exp);
      value_errs++;
    end
  endtask

  initial begin : main_seq
    int          fd;
    int          n;
    int          code;
    int          ch;
    int unsigned seed;
    logic [7:0]  op;
    logic [63:0] arg_a;
    logic [63:0] arg_b;

    seed       = $urandom(47308);
    clk        = 1'b0;
    rst_n      = 1'b0;
    wr_push    = 1'b0;
    wr_word    = '0;
    req        = 1'b0;
    req_write  = 1'b0;
    req_addr   = '0;
    rd_sel     = '0;
    value_errs = 0;
    other_errs = 0;
    done_seen  = 0;
    done_exp   = 0;
    fill_model = 0;
    pending    = 1'b0;

    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    if (ready !== 1'b0) begin
      $display("[FAIL] ready got 0x%h expected 0x0", ready);
      value_errs++;
    end
    n = 0;
    while (!ready && n < TIMEOUT) begin   // calibration
      if (done !== 1'b0) begin
        $display("[FAIL] done got 0x%h expected 0x0", done);
        value_errs++;
      end
      next_cycle();
      n++;
    end
    if (!ready) begin
      $display("timeout while waiting for ready after reset");
      other_errs++;
    end

    fd = $fopen("burst_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open burst_stim.txt");
      other_errs++;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, " %c", op);
        if (code == 1) begin
          if (op != "#" && op != "X") begin
            finish_pending();
            repeat ($urandom % 4) next_cycle();   // idle gap
          end
          case (op)
            "#": begin
              ch = $fgetc(fd);
              while (ch != "\n" && ch != -1) begin
                ch = $fgetc(fd);
              end
            end
            "P": begin
              code = $fscanf(fd, "%h", arg_a);
              push_word(arg_a);
            end
            "W", "R", "X": begin
              code = $fscanf(fd, "%h", arg_a);
              if (op == "X") begin
                stray_req(arg_a[mem_types_pkg::ADDR_W-1:0]);
              end else begin
                issue_req(op == "W", arg_a[mem_types_pkg::ADDR_W-1:0]);
              end
            end
            "C": begin
              code = $fscanf(fd, "%h %h", arg_a, arg_b);
              check_word(arg_a[SEL_W-1:0], arg_b);
            end
            default: begin
              $display("unknown operation in the stimulus file");
              other_errs++;
            end
          endcase
        end
      end
      finish_pending();
      $fclose(fd);
    end

    repeat (10) next_cycle();   // room for a stray done
    if (done_seen != done_exp) begin
      $display("[FAIL] done_count got 0x%h expected 0x%h", done_seen, done_exp);
      value_errs++;
    end

    $display("errors: %0d wrong value, %0d other", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* burst_stim.txt */
# one operation per line, values in hex: P word | W addr | R addr | X addr | C index word
# X is a write request made while busy, C checks rd_word at rd_sel index
P a0a0a0a000000000
P a0a0a0a000000001
P a0a0a0a000000002
P a0a0a0a000000003
W 10
R 10
C 0 a0a0a0a000000000
C 1 a0a0a0a000000001
C 2 a0a0a0a000000002
C 3 a0a0a0a000000003
P b1b1b1b100000010
P b1b1b1b100000011
P b1b1b1b100000012
P b1b1b1b100000013
P deadbeefdeadbeef
W 20
R 20
C 0 b1b1b1b100000010
C 3 b1b1b1b100000013
R 10
C 1 a0a0a0a000000001
P c2c2c2c200000020
P c2c2c2c200000021
P c2c2c2c200000022
P c2c2c2c200000023
W 10
R 10
C 0 c2c2c2c200000020
C 3 c2c2c2c200000023
W 30
X 20
R 20
C 1 b1b1b1b100000011
C 2 b1b1b1b100000012
R 30
C 2 c2c2c2c200000022

/* src.f */
mem_types_pkg.sv
mem_ctrl_pkg.sv
burst_ram.sv
line_ctrl.sv
wr_line_buf.sv
rd_line_buf.sv
burst_mem_top.sv
tb_burst_mem.sv
